// ==== Bender.yml ====
package:
  name: dma_mstr

sources:
  - verilog/cmd_reg_pkg.sv
  - verilog/axi_mstr_pkg.sv
  - verilog/lane_align.sv
  - verilog/cmd_regs.sv
  - verilog/axi_single_mstr.sv
  - verilog/dma_mstr_top.sv
  - target: test
    files:
      - dv/dma_mstr_assertions.sv
      - dv/dma_mstr_tb.sv

// ==== dv/dma_mstr_assertions.sv ====
// AXI handshake assertions
`default_nettype none

module dma_mstr_assertions (
  input  wire                        aclk,
  input  wire                        rst_n,
  input  wire axi_mstr_pkg::mstr_state_e state_q,
  input  wire                        awvalid,
  input  wire                        awready,
  input  wire                        wvalid,
  input  wire                        wready,
  input  wire                        arvalid,
  input  wire                        arready
);

  int unsigned fail_cnt = 0;   // read by the testbench at the end

  // --------------------------------------
  // valid held until ready
  // --------------------------------------

  aw_hold: assert property (@(posedge aclk) disable iff (!rst_n)
    awvalid && !awready |=> awvalid)
    else begin fail_cnt++; $error("awvalid dropped before awready"); end

  ar_hold: assert property (@(posedge aclk) disable iff (!rst_n)
    arvalid && !arready |=> arvalid)
    else begin fail_cnt++; $error("arvalid dropped before arready"); end

  w_hold: assert property (@(posedge aclk) disable iff (!rst_n)
    wvalid && !wready |=> wvalid)
    else begin fail_cnt++; $error("wvalid dropped before wready"); end

  // W only follows an accepted AW
  w_after_aw: assert property (@(posedge aclk) disable iff (!rst_n)
    $rose(wvalid) |-> $past(awvalid && awready))
    else begin fail_cnt++; $error("wvalid rose without an AW handshake"); end

  // idle means quiet channels
  idle_quiet: assert property (@(posedge aclk) disable iff (!rst_n)
    state_q == axi_mstr_pkg::idle |-> !(awvalid || wvalid || arvalid))
    else begin fail_cnt++; $error("valid high while the FSM is idle"); end

endmodule

`default_nettype wire

// ==== dv/dma_mstr_tb.sv ====
// AXI master testbench
`default_nettype none

module dma_mstr_tb;

  logic         aclk;
  logic         rst_n;
  logic         cfg_wr;
  logic         cfg_rd;
  logic [7:0]   cfg_addr;
  logic [31:0]  cfg_wdata;
  logic [31:0]  cfg_rdata;
  logic         cfg_ack;
  logic [63:0]  awaddr;
  logic         awvalid;
  logic         awready = 1'b0;
  logic [511:0] wdata;
  logic [63:0]  wstrb;
  logic         wvalid;
  logic         wready = 1'b0;
  logic         bvalid = 1'b0;
  logic         bready;
  logic [63:0]  araddr;
  logic         arvalid;
  logic         arready = 1'b0;
  logic [511:0] rdata = '0;
  logic         rvalid = 1'b0;
  logic         rready;

  logic [31:0]  stim_seed  = 32'h16df0f34;
  logic [31:0]  slave_seed = 32'h16df0f34;   // separate stream for the slave
  logic [63:0]  exp_addr   = '0;             // current command, for the compare process
  logic [31:0]  exp_word   = '0;
  logic         b_phase    = 1'b0;           // between W and B handshakes
  logic         r_phase    = 1'b0;           // between AR and R handshakes
  int unsigned  err_cnt    = 0;
  int unsigned  check_cnt  = 0;
  int unsigned  test_cnt   = 0;
  int unsigned  err_base   = 0;
  int unsigned  b_cnt      = 0;              // completed B handshakes
  int unsigned  r_cnt      = 0;              // completed R handshakes

  // slave model state
  logic [511:0] mem [logic [57:0]];          // sparse, keyed by line
  logic [57:0]  aw_line;
  logic [57:0]  ar_line;
  logic [1:0]   aw_dly = '0;
  logic [1:0]   w_dly  = '0;
  logic [1:0]   b_dly  = '0;
  logic [1:0]   ar_dly = '0;
  logic [1:0]   r_dly  = '0;
  logic         b_pend = 1'b0;
  logic         r_pend = 1'b0;

  dma_mstr_top dut_i (
    .aclk(aclk), .rst_n(rst_n),
    .cfg_wr(cfg_wr), .cfg_rd(cfg_rd), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata),
    .cfg_rdata(cfg_rdata), .cfg_ack(cfg_ack),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rvalid(rvalid), .rready(rready)
  );

  bind axi_single_mstr dma_mstr_assertions hs_chk_i (
    .aclk(aclk), .rst_n(rst_n), .state_q(state_q),
    .awvalid(awvalid), .awready(awready), .wvalid(wvalid), .wready(wready),
    .arvalid(arvalid), .arready(arready)
  );

  initial begin
    aclk = 1'b0;
    forever #20 aclk = ~aclk;   // period 40
  end

  // --------------------------------------
  // random numbers and reference model
  // --------------------------------------

  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] rand_word();
    stim_seed = lcg(stim_seed);
    return stim_seed;
  endfunction

  function automatic logic [1:0] rand_delay();
    slave_seed = lcg(slave_seed);
    return slave_seed[17:16];   // upper bits, low ones cycle too fast
  endfunction

  // word bytes go to off..off+3, anything past byte 63 is lost
  function automatic logic [511:0] ref_wr_line(input logic [5:0] off, input logic [31:0] w);
    logic [511:0] line;
    int o;
    line = '0;
    o = off;
    for (int b = 0; b < 4; b++)
      if (o + b < 64) line[(o+b)*8 +: 8] = w[b*8 +: 8];
    return line;
  endfunction

  function automatic logic [63:0] ref_wr_strb(input logic [5:0] off);
    logic [63:0] strb;
    int o;
    strb = '0;
    o = off;
    for (int b = 0; b < 4; b++)
      if (o + b < 64) strb[o+b] = 1'b1;
    return strb;
  endfunction

  // bytes past 63 read as zero
  function automatic logic [31:0] ref_rd_word(input logic [5:0] off, input logic [511:0] line);
    logic [31:0] w;
    int o;
    w = '0;
    o = off;
    for (int b = 0; b < 4; b++)
      if (o + b < 64) w[b*8 +: 8] = line[(o+b)*8 +: 8];
    return w;
  endfunction

  task automatic check_val(input string name, input logic [511:0] expected,
                           input logic [511:0] got);
    check_cnt++;
    if (expected !== got) begin
      $display("Fail %s expected %0h got %0h", name, expected, got);
      err_cnt++;
    end
  endtask

  // --------------------------------------
  // AXI slave model
  // --------------------------------------

  always @(posedge aclk) begin : slave_model
    logic [511:0] line;
    if (!rst_n) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
      arready <= 1'b0;
      rvalid  <= 1'b0;
      b_pend  <= 1'b0;
      r_pend  <= 1'b0;
    end else begin
      // AW
      if (awvalid && awready) begin
        awready <= 1'b0;
        aw_line <= awaddr[63:6];
        aw_dly  <= rand_delay();
      end else if (awvalid) begin
        if (aw_dly == 0) awready <= 1'b1;
        else aw_dly <= aw_dly - 1'b1;
      end
      // W, merge strobed bytes into the line
      if (wvalid && wready) begin
        wready <= 1'b0;
        w_dly  <= rand_delay();
        line = mem.exists(aw_line) ? mem[aw_line] : '0;
        for (int i = 0; i < 64; i++)
          if (wstrb[i]) line[i*8 +: 8] = wdata[i*8 +: 8];
        mem[aw_line] = line;
        b_pend <= 1'b1;
        b_dly  <= rand_delay();
      end else if (wvalid) begin
        if (w_dly == 0) wready <= 1'b1;
        else w_dly <= w_dly - 1'b1;
      end
      // B
      if (bvalid && bready) begin
        bvalid <= 1'b0;
        b_cnt  <= b_cnt + 1;
      end else if (b_pend && !bvalid) begin
        if (b_dly == 0) begin
          bvalid <= 1'b1;
          b_pend <= 1'b0;
        end else b_dly <= b_dly - 1'b1;
      end
      // AR
      if (arvalid && arready) begin
        arready <= 1'b0;
        ar_line <= araddr[63:6];
        ar_dly  <= rand_delay();
        r_pend  <= 1'b1;
        r_dly   <= rand_delay();
      end else if (arvalid) begin
        if (ar_dly == 0) arready <= 1'b1;
        else ar_dly <= ar_dly - 1'b1;
      end
      // R
      if (rvalid && rready) begin
        rvalid <= 1'b0;
        r_cnt  <= r_cnt + 1;
      end else if (r_pend && !rvalid) begin
        if (r_dly == 0) begin
          rvalid <= 1'b1;
          rdata  <= mem.exists(ar_line) ? mem[ar_line] : '0;
          r_pend <= 1'b0;
        end else r_dly <= r_dly - 1'b1;
      end
    end
  end

  // compare process, payload against the reference at each handshake
  always @(posedge aclk) begin
    if (rst_n) begin
      if (awvalid && awready) check_val("awaddr", exp_addr, awaddr);
      if (arvalid && arready) check_val("araddr", exp_addr, araddr);
      if (wvalid && wready) begin
        check_val("wdata", ref_wr_line(exp_addr[5:0], exp_word), wdata);
        check_val("wstrb", ref_wr_strb(exp_addr[5:0]), wstrb);
      end
      // response readies only while a response is owed
      check_val("bready", b_phase, bready);
      check_val("rready", r_phase, rready);
      if (wvalid && wready) b_phase <= 1'b1;
      else if (bvalid && bready) b_phase <= 1'b0;
      if (arvalid && arready) r_phase <= 1'b1;
      else if (rvalid && rready) r_phase <= 1'b0;
    end
  end

  // --------------------------------------
  // config bus driver
  // --------------------------------------

  task automatic cfg_access(input logic wr, input logic [7:0] addr, input logic [31:0] wd,
                            output logic [31:0] rd);
    int   lat;
    logic got;
    lat = 0;
    got = 1'b0;
    @(posedge aclk);
    cfg_wr    <= wr;
    cfg_rd    <= ~wr;
    cfg_addr  <= addr;
    cfg_wdata <= wd;
    while (!got && lat < 8) begin
      @(posedge aclk);
      cfg_wr <= 1'b0;    // one cycle pulse
      cfg_rd <= 1'b0;
      lat++;
      @(negedge aclk);   // sample away from the edge
      got = cfg_ack;
    end
    rd = cfg_rdata;
    if (!got) begin
      $display("config access to offset %0h never got an ack", addr);
      err_cnt++;
    end else begin
      check_val("cfg_ack_latency", 2, lat);
    end
  endtask

  task automatic reg_write(input logic [7:0] addr, input logic [31:0] wd);
    logic [31:0] unused;
    cfg_access(1'b1, addr, wd, unused);
  endtask

  task automatic reg_read(input logic [7:0] addr, output logic [31:0] rd);
    cfg_access(1'b0, addr, '0, rd);
  endtask

  // poll CCR until done
  task automatic wait_done(output logic [31:0] ccr_final);
    cmd_reg_pkg::ccr_word_u ccr;
    int polls;
    ccr.raw = '0;
    polls = 0;
    while (!ccr.fld.done && polls < 40) begin
      reg_read(cmd_reg_pkg::ccr_off, ccr.raw);
      polls++;
    end
    if (!ccr.fld.done) begin
      $display("command did not complete, done never set");
      err_cnt++;
    end
    ccr_final = ccr.raw;
  endtask

  // load the registers, set go, wait for done
  task automatic run_cmd(input logic rd, input logic [63:0] addr, input logic [31:0] word);
    cmd_reg_pkg::ccr_word_u ccr;
    logic [31:0] got;
    int unsigned b_before;
    int unsigned r_before;
    b_before = b_cnt;
    r_before = r_cnt;
    exp_addr = addr;
    exp_word = word;
    reg_write(cmd_reg_pkg::cahr_off, addr[63:32]);
    reg_write(cmd_reg_pkg::calr_off, addr[31:0]);
    if (!rd) reg_write(cmd_reg_pkg::cwdr_off, word);
    ccr.raw = '0;
    ccr.fld.go     = 1'b1;
    ccr.fld.rd_wrb = rd;
    reg_write(cmd_reg_pkg::ccr_off, ccr.raw);
    wait_done(got);
    ccr.raw = '0;
    ccr.fld.done   = 1'b1;   // go consumed by the launch
    ccr.fld.rd_wrb = rd;
    check_val("ccr", ccr.raw, got);
    check_val("b_count", b_before + (rd ? 0 : 1), b_cnt);
    check_val("r_count", r_before + (rd ? 1 : 0), r_cnt);
  endtask

  task automatic end_test(input string name);
    test_cnt++;
    $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - err_base);
    err_base = err_cnt;
  endtask

  // --------------------------------------
  // tests
  // --------------------------------------

  initial begin : main
    logic [31:0]  vals [4];
    logic [31:0]  got;
    logic [31:0]  tmp;
    logic [63:0]  addr;
    logic [5:0]   off;
    logic [31:0]  word;
    logic [511:0] pre_line;
    logic         launched;
    cmd_reg_pkg::ccr_word_u ccr;

    rst_n     = 1'b0;
    cfg_wr    = 1'b0;
    cfg_rd    = 1'b0;
    cfg_addr  = '0;
    cfg_wdata = '0;
    repeat (4) @(posedge aclk);
    rst_n <= 1'b1;

    // 1: register access
    reg_read(cmd_reg_pkg::ccr_off, got);
    check_val("ccr", 0, got);
    for (int i = 0; i < 4; i++) vals[i] = rand_word();
    reg_write(cmd_reg_pkg::cahr_off, vals[0]);
    reg_write(cmd_reg_pkg::calr_off, vals[1]);
    reg_write(cmd_reg_pkg::cwdr_off, vals[2]);
    reg_write(cmd_reg_pkg::crdr_off, vals[3]);
    reg_read(cmd_reg_pkg::cahr_off, got);
    check_val("cahr", vals[0], got);
    reg_read(cmd_reg_pkg::calr_off, got);
    check_val("calr", vals[1], got);
    reg_read(cmd_reg_pkg::cwdr_off, got);
    check_val("cwdr", vals[2], got);
    reg_read(cmd_reg_pkg::crdr_off, got);
    check_val("crdr", vals[3], got);
    reg_read(8'h14, got);
    check_val("cfg_rdata", 32'hffff_ffff, got);
    reg_read(8'h02, got);
    check_val("cfg_rdata", 32'hffff_ffff, got);
    reg_read(8'hfc, got);
    check_val("cfg_rdata", 32'hffff_ffff, got);
    end_test("register access");

    // 2: write commands, edge lanes included
    for (int i = 0; i < 5; i++) begin
      tmp = rand_word();
      case (i)
        0: off = 6'd0;
        1: off = 6'd61;
        2: off = 6'd63;
        default: off = tmp[5:0];
      endcase
      addr = {rand_word(), rand_word()};
      addr[5:0] = off;
      run_cmd(1'b0, addr, rand_word());
    end
    end_test("write commands");

    // 3: read commands from preloaded lines
    for (int i = 0; i < 5; i++) begin
      tmp = rand_word();
      case (i)
        0: off = 6'd0;
        1: off = 6'd62;
        2: off = 6'd63;
        default: off = tmp[5:0];
      endcase
      addr = {rand_word(), rand_word()};
      addr[5:0] = off;
      for (int k = 0; k < 16; k++) pre_line[k*32 +: 32] = rand_word();
      mem[addr[63:6]] = pre_line;
      run_cmd(1'b1, addr, '0);
      reg_read(cmd_reg_pkg::crdr_off, got);
      check_val("crdr", ref_rd_word(off, pre_line), got);
    end
    end_test("read commands");

    // 4: go with done still set is ignored
    ccr.raw = '0;
    ccr.fld.go   = 1'b1;
    ccr.fld.done = 1'b1;
    reg_write(cmd_reg_pkg::ccr_off, ccr.raw);
    launched = 1'b0;
    for (int cyc = 0; cyc < 20; cyc++) begin
      @(negedge aclk);
      if (awvalid || arvalid) launched = 1'b1;
    end
    if (launched) begin
      $display("a command launched while done was still set");
      err_cnt++;
    end
    reg_write(cmd_reg_pkg::ccr_off, 32'h0);   // clear done
    addr = {rand_word(), rand_word()};
    run_cmd(1'b0, addr, rand_word());
    end_test("go blocked by done");

    // 5: write then read back the same word
    for (int i = 0; i < 4; i++) begin
      tmp  = rand_word();
      off  = tmp[5:0] % 61;   // whole word inside the line
      addr = {rand_word(), rand_word()};
      addr[5:0] = off;
      word = rand_word();
      run_cmd(1'b0, addr, word);
      run_cmd(1'b1, addr, '0);
      reg_read(cmd_reg_pkg::crdr_off, got);
      check_val("crdr", word, got);
    end
    end_test("write then read");

    if (dut_i.axi_single_mstr_i.hs_chk_i.fail_cnt != 0) begin
      $display("handshake assertions failed %0d times",
               dut_i.axi_single_mstr_i.hs_chk_i.fail_cnt);
      err_cnt += dut_i.axi_single_mstr_i.hs_chk_i.fail_cnt;
    end
    $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/axi_mstr_pkg.sv ====
// AXI master port definitions
`default_nettype none

package axi_mstr_pkg;

  // --------------------------------------
  // memory port widths
  // --------------------------------------

  localparam int unsigned axi_addr_w = 64;
  localparam int unsigned axi_data_w = 512;            // one full line per beat
  localparam int unsigned axi_strb_w = axi_data_w / 8; // a strobe bit per byte

  // byte offset inside a line, i.e. address bits 5:0
  localparam int unsigned lane_sel_w = $clog2(axi_strb_w);

  // every transfer moves one word of this many bytes
  localparam int unsigned word_bytes = 4;

  // --------------------------------------
  // command FSM
  // --------------------------------------

  // write goes AW, W, B and read goes AR, R
  typedef enum logic [2:0] {
    idle    = 3'd0,   // waiting for go
    wr_addr = 3'd1,   // awvalid up
    wr_data = 3'd2,   // wvalid up, only after AW
    wr_resp = 3'd3,   // bready up
    rd_addr = 3'd4,   // arvalid up
    rd_data = 3'd5    // rready up
  } mstr_state_e;

  // codes 6 and 7 are not reached

endpackage

`default_nettype wire

// ==== verilog/axi_single_mstr.sv ====
// single beat AXI command FSM
`default_nettype none

module axi_single_mstr (
  input  wire   aclk,
  input  wire   rst_n,
  // command from the register file
  input  wire   cmd_start,     // go set and done clear
  input  wire   cmd_rd_wrb,    // 1 read, 0 write
  // write address channel
  output logic  awvalid,
  input  wire   awready,
  // write data channel
  output logic  wvalid,
  input  wire   wready,
  // write response channel, bresp ignored
  input  wire   bvalid,
  output logic  bready,
  // read address channel
  output logic  arvalid,
  input  wire   arready,
  // read data channel, rresp ignored
  input  wire   rvalid,
  output logic  rready,
  // status back to the register file
  output logic  mstr_idle,
  output logic  cmd_finish,    // one cycle, B or R handshake
  output logic  rd_word_vld    // one cycle, R handshake
);

  axi_mstr_pkg::mstr_state_e state_q;
  axi_mstr_pkg::mstr_state_e state_d;

  // --------------------------------------
  // next state
  // --------------------------------------

  always_comb begin
    state_d = state_q;   // hold while the slave stalls
    case (state_q)
      axi_mstr_pkg::idle: begin
        if (cmd_start) begin
          if (cmd_rd_wrb)
            state_d = axi_mstr_pkg::rd_addr;
          else
            state_d = axi_mstr_pkg::wr_addr;
        end
      end
      axi_mstr_pkg::wr_addr: begin
        if (awready)
          state_d = axi_mstr_pkg::wr_data;   // W only after AW accepted
      end
      axi_mstr_pkg::wr_data: begin
        if (wready)
          state_d = axi_mstr_pkg::wr_resp;
      end
      axi_mstr_pkg::wr_resp: begin
        if (bvalid)
          state_d = axi_mstr_pkg::idle;
      end
      axi_mstr_pkg::rd_addr: begin
        if (arready)
          state_d = axi_mstr_pkg::rd_data;
      end
      axi_mstr_pkg::rd_data: begin
        if (rvalid)
          state_d = axi_mstr_pkg::idle;
      end
      default: state_d = axi_mstr_pkg::idle;  // unused codes recover
    endcase
  end

  // --------------------------------------
  // state register
  // --------------------------------------

  always_ff @(posedge aclk) begin
    if (!rst_n)
      state_q <= axi_mstr_pkg::idle;
    else
      state_q <= state_d;
  end

  // --------------------------------------
  // channel controls
  // --------------------------------------

  // each valid is a pure state decode, so it stays up under back-pressure
  assign awvalid = (state_q == axi_mstr_pkg::wr_addr);
  assign wvalid  = (state_q == axi_mstr_pkg::wr_data);
  assign bready  = (state_q == axi_mstr_pkg::wr_resp);
  assign arvalid = (state_q == axi_mstr_pkg::rd_addr);
  assign rready  = (state_q == axi_mstr_pkg::rd_data);

  assign mstr_idle   = (state_q == axi_mstr_pkg::idle);
  assign rd_word_vld = rready & rvalid;                  // load CRDR
  assign cmd_finish  = (bready & bvalid) | rd_word_vld;  // set done

endmodule

`default_nettype wire

// ==== verilog/cmd_reg_pkg.sv ====
// command register map
`default_nettype none

package cmd_reg_pkg;

  // --------------------------------------
  // config bus widths
  // --------------------------------------

  // only the low offset bits reach this block
  localparam int unsigned cfg_addr_w = 8;
  localparam int unsigned cfg_data_w = 32;   // one register word

  // --------------------------------------
  // register offsets
  // --------------------------------------

  localparam logic [cfg_addr_w-1:0] ccr_off  = 8'h00;  // command control
  localparam logic [cfg_addr_w-1:0] cahr_off = 8'h04;  // target address, upper half
  localparam logic [cfg_addr_w-1:0] calr_off = 8'h08;  // target address, lower half
  localparam logic [cfg_addr_w-1:0] cwdr_off = 8'h0C;  // word to write
  localparam logic [cfg_addr_w-1:0] crdr_off = 8'h10;  // word fetched by a read

  // any hole in the map reads as this
  localparam logic [cfg_data_w-1:0] unmapped_rdata = 32'hffff_ffff;

  // --------------------------------------
  // command control word
  // --------------------------------------

  // either the whole word or its control bits
  typedef union packed {
    logic [cfg_data_w-1:0] raw;
    struct packed {
      logic [28:0] rsvd;     // reads as zero
      logic        rd_wrb;   // 1 read, 0 write
      logic        done;     // set when the B or R handshake completes
      logic        go;       // launch request
    } fld;
  } ccr_word_u;

endpackage

`default_nettype wire

// ==== verilog/cmd_regs.sv ====
// command register file
`default_nettype none

module cmd_regs (
  input  wire                                  aclk,
  input  wire                                  rst_n,
  // config bus, one-cycle wr/rd pulse
  input  wire                                  cfg_wr,
  input  wire                                  cfg_rd,
  input  wire  [cmd_reg_pkg::cfg_addr_w-1:0]   cfg_addr,
  input  wire  [cmd_reg_pkg::cfg_data_w-1:0]   cfg_wdata,
  output logic [cmd_reg_pkg::cfg_data_w-1:0]   cfg_rdata,
  output logic                                 cfg_ack,
  // status back from the FSM
  input  wire                                  mstr_idle,
  input  wire                                  cmd_finish,
  input  wire                                  rd_word_vld,
  input  wire  [cmd_reg_pkg::cfg_data_w-1:0]   rd_word,
  // command towards FSM and lane aligner
  output logic                                 cmd_start,
  output logic                                 cmd_rd_wrb,
  output logic [axi_mstr_pkg::axi_addr_w-1:0]  cmd_addr,
  output logic [cmd_reg_pkg::cfg_data_w-1:0]   cmd_wr_data
);

  logic                               wr_stretch;   // wr held until ack
  logic                               rd_stretch;   // rd held until ack
  logic [cmd_reg_pkg::cfg_addr_w-1:0] cfg_addr_q;
  cmd_reg_pkg::ccr_word_u             cfg_wdata_q;  // captured write word
  logic                               reg_we;
  logic                               rd_sample;
  logic                               go_q;
  logic                               done_q;
  logic                               rd_wrb_q;
  logic [cmd_reg_pkg::cfg_data_w-1:0] addr_hi_q;    // CAHR
  logic [cmd_reg_pkg::cfg_data_w-1:0] addr_lo_q;    // CALR
  logic [cmd_reg_pkg::cfg_data_w-1:0] wr_data_q;    // CWDR
  logic [cmd_reg_pkg::cfg_data_w-1:0] rd_data_q;    // CRDR
  cmd_reg_pkg::ccr_word_u             ccr_rd;       // CCR as read back

  // --------------------------------------
  // config access and ack
  // --------------------------------------

  // pulse at N, stretch from N+1, ack at N+2 for one cycle
  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      wr_stretch <= 1'b0;
      rd_stretch <= 1'b0;
      cfg_ack    <= 1'b0;
    end else begin
      wr_stretch <= cfg_wr | (wr_stretch & ~cfg_ack);
      rd_stretch <= cfg_rd | (rd_stretch & ~cfg_ack);
      cfg_ack    <= (wr_stretch | rd_stretch) & ~cfg_ack;
    end
  end

  always_ff @(posedge aclk) begin
    if (cfg_wr | cfg_rd) begin
      cfg_addr_q      <= cfg_addr;
      cfg_wdata_q.raw <= cfg_wdata;
    end
  end

  assign reg_we    = wr_stretch & ~cfg_ack;  // lands on the edge ack rises
  assign rd_sample = rd_stretch & ~cfg_ack;

  // --------------------------------------
  // CCR
  // --------------------------------------

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      go_q     <= 1'b0;
      done_q   <= 1'b0;
      rd_wrb_q <= 1'b0;
    end else if (reg_we && (cfg_addr_q == cmd_reg_pkg::ccr_off)) begin
      go_q     <= cfg_wdata_q.fld.go;
      done_q   <= cfg_wdata_q.fld.done;
      rd_wrb_q <= cfg_wdata_q.fld.rd_wrb;
    end else begin
      go_q   <= go_q & mstr_idle;       // held until the FSM leaves idle
      done_q <= done_q | cmd_finish;    // sticky until host clears it
    end
  end

  // --------------------------------------
  // address and data registers
  // --------------------------------------

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      addr_hi_q <= '0;
      addr_lo_q <= '0;
      wr_data_q <= '0;
      rd_data_q <= '0;
    end else begin
      if (reg_we && (cfg_addr_q == cmd_reg_pkg::cahr_off))
        addr_hi_q <= cfg_wdata_q.raw;
      if (reg_we && (cfg_addr_q == cmd_reg_pkg::calr_off))
        addr_lo_q <= cfg_wdata_q.raw;
      if (reg_we && (cfg_addr_q == cmd_reg_pkg::cwdr_off))
        wr_data_q <= cfg_wdata_q.raw;
      if (reg_we && (cfg_addr_q == cmd_reg_pkg::crdr_off))
        rd_data_q <= cfg_wdata_q.raw;   // host may preset it
      else if (rd_word_vld)
        rd_data_q <= rd_word;           // fetched word on R handshake
    end
  end

  // --------------------------------------
  // readback
  // --------------------------------------

  always_comb begin
    ccr_rd.fld.rsvd   = '0;
    ccr_rd.fld.rd_wrb = rd_wrb_q;
    ccr_rd.fld.done   = done_q;
    ccr_rd.fld.go     = go_q;
  end

  // valid in the ack cycle
  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      cfg_rdata <= '0;
    end else if (rd_sample) begin
      case (cfg_addr_q)
        cmd_reg_pkg::ccr_off:  cfg_rdata <= ccr_rd.raw;
        cmd_reg_pkg::cahr_off: cfg_rdata <= addr_hi_q;
        cmd_reg_pkg::calr_off: cfg_rdata <= addr_lo_q;
        cmd_reg_pkg::cwdr_off: cfg_rdata <= wr_data_q;
        cmd_reg_pkg::crdr_off: cfg_rdata <= rd_data_q;
        default:               cfg_rdata <= cmd_reg_pkg::unmapped_rdata;
      endcase
    end
  end

  assign cmd_start   = go_q & ~done_q;          // no relaunch until done cleared
  assign cmd_rd_wrb  = rd_wrb_q;
  assign cmd_addr    = {addr_hi_q, addr_lo_q};
  assign cmd_wr_data = wr_data_q;

endmodule

`default_nettype wire

// ==== verilog/dma_mstr_top.sv ====
// register controlled AXI master top
`default_nettype none

module dma_mstr_top (
  input  wire                                  aclk,
  input  wire                                  rst_n,
  // --------------------------------------
  // config bus
  // --------------------------------------
  input  wire                                  cfg_wr,
  input  wire                                  cfg_rd,
  input  wire  [cmd_reg_pkg::cfg_addr_w-1:0]   cfg_addr,
  input  wire  [cmd_reg_pkg::cfg_data_w-1:0]   cfg_wdata,
  output logic [cmd_reg_pkg::cfg_data_w-1:0]   cfg_rdata,
  output logic                                 cfg_ack,
  // --------------------------------------
  // AXI4 memory port
  // --------------------------------------
  output logic [axi_mstr_pkg::axi_addr_w-1:0]  awaddr,
  output logic                                 awvalid,
  input  wire                                  awready,
  output logic [axi_mstr_pkg::axi_data_w-1:0]  wdata,
  output logic [axi_mstr_pkg::axi_strb_w-1:0]  wstrb,
  output logic                                 wvalid,
  input  wire                                  wready,
  input  wire                                  bvalid,
  output logic                                 bready,
  output logic [axi_mstr_pkg::axi_addr_w-1:0]  araddr,
  output logic                                 arvalid,
  input  wire                                  arready,
  input  wire  [axi_mstr_pkg::axi_data_w-1:0]  rdata,
  input  wire                                  rvalid,
  output logic                                 rready
);

  logic                                 cmd_start;
  logic                                 cmd_rd_wrb;
  logic [axi_mstr_pkg::axi_addr_w-1:0]  cmd_addr;     // CAHR and CALR joined
  logic [cmd_reg_pkg::cfg_data_w-1:0]   cmd_wr_data;
  logic [cmd_reg_pkg::cfg_data_w-1:0]   rd_word;      // word pulled from rdata
  logic                                 mstr_idle;
  logic                                 cmd_finish;
  logic                                 rd_word_vld;

  cmd_regs cmd_regs_i (
    .aclk        (aclk),
    .rst_n       (rst_n),
    .cfg_wr      (cfg_wr),
    .cfg_rd      (cfg_rd),
    .cfg_addr    (cfg_addr),
    .cfg_wdata   (cfg_wdata),
    .cfg_rdata   (cfg_rdata),
    .cfg_ack     (cfg_ack),
    .mstr_idle   (mstr_idle),
    .cmd_finish  (cmd_finish),
    .rd_word_vld (rd_word_vld),
    .rd_word     (rd_word),
    .cmd_start   (cmd_start),
    .cmd_rd_wrb  (cmd_rd_wrb),
    .cmd_addr    (cmd_addr),
    .cmd_wr_data (cmd_wr_data)
  );

  axi_single_mstr axi_single_mstr_i (
    .aclk        (aclk),
    .rst_n       (rst_n),
    .cmd_start   (cmd_start),
    .cmd_rd_wrb  (cmd_rd_wrb),
    .awvalid     (awvalid),
    .awready     (awready),
    .wvalid      (wvalid),
    .wready      (wready),
    .bvalid      (bvalid),
    .bready      (bready),
    .arvalid     (arvalid),
    .arready     (arready),
    .rvalid      (rvalid),
    .rready      (rready),
    .mstr_idle   (mstr_idle),
    .cmd_finish  (cmd_finish),
    .rd_word_vld (rd_word_vld)
  );

  lane_align lane_align_i (
    .lane_sel   (cmd_addr[axi_mstr_pkg::lane_sel_w-1:0]),  // byte within line
    .wr_word    (cmd_wr_data),
    .rdata      (rdata),
    .line_wdata (wdata),
    .line_wstrb (wstrb),
    .rd_word    (rd_word)
  );

  // same target for both directions
  assign awaddr = cmd_addr;
  assign araddr = cmd_addr;

endmodule

`default_nettype wire

// ==== verilog/lane_align.sv ====
// byte lane alignment
`default_nettype none

module lane_align (
  input  wire  [axi_mstr_pkg::lane_sel_w-1:0]    lane_sel,   // address bits 5:0
  input  wire  [axi_mstr_pkg::word_bytes*8-1:0]  wr_word,
  input  wire  [axi_mstr_pkg::axi_data_w-1:0]    rdata,
  output logic [axi_mstr_pkg::axi_data_w-1:0]    line_wdata,
  output logic [axi_mstr_pkg::axi_strb_w-1:0]    line_wstrb,
  output logic [axi_mstr_pkg::word_bytes*8-1:0]  rd_word
);

  logic [axi_mstr_pkg::lane_sel_w+2:0]  bit_sel;    // byte offset in bits
  logic [axi_mstr_pkg::axi_data_w-1:0]  word_line;  // write word at lane 0
  logic [axi_mstr_pkg::axi_strb_w-1:0]  word_strb;  // strobes at lane 0
  logic [axi_mstr_pkg::axi_data_w-1:0]  rd_line;    // line moved down to lane 0

  assign bit_sel = {lane_sel, 3'b000};

  // --------------------------------------
  // write side
  // --------------------------------------

  assign word_line = {{(axi_mstr_pkg::axi_data_w - axi_mstr_pkg::word_bytes*8){1'b0}},
                      wr_word};
  assign word_strb = {{(axi_mstr_pkg::axi_strb_w - axi_mstr_pkg::word_bytes){1'b0}},
                      {axi_mstr_pkg::word_bytes{1'b1}}};

  // bytes pushed past byte 63 fall off the top
  assign line_wdata = word_line << bit_sel;
  assign line_wstrb = word_strb << lane_sel;

  // --------------------------------------
  // read side
  // --------------------------------------

  // zero fill from the top, so bytes past 63 come back as zero
  assign rd_line = rdata >> bit_sel;
  assign rd_word = rd_line[axi_mstr_pkg::word_bytes*8-1:0];

endmodule

`default_nettype wire

// ==== vlog.f ====
verilog/cmd_reg_pkg.sv
verilog/axi_mstr_pkg.sv
verilog/lane_align.sv
verilog/cmd_regs.sv
verilog/axi_single_mstr.sv
verilog/dma_mstr_top.sv
dv/dma_mstr_assertions.sv
dv/dma_mstr_tb.sv
